// File: rtl/lsu_pkg.sv
//----------------------------------------------------------
// Shared definitions for the load-store execute unit
// Micro-op encoding and fixed data and register widths
//----------------------------------------------------------

package lsu_pkg;

  //----------------------------------------------------------
  // Widths
  //----------------------------------------------------------

  // Data word and byte address width
  localparam int data_w = 32;

  // Architectural register index
  localparam int reg_addr_w = 5;

  //----------------------------------------------------------
  // Micro-ops
  //----------------------------------------------------------

  // Word load and word store only
  typedef enum logic {
    op_lw = 1'b0,
    op_sw = 1'b1
  } lsu_op_e;

endpackage

// File: rtl/lsu_issue.sv
//----------------------------------------------------------
// Issue stage of the load-store unit
// Address adder, one-entry memory request register, D stall
//----------------------------------------------------------

`timescale 1ns/1ns

module lsu_issue #(
  parameter int seq_num_w = 5
) (
  input  logic                           clk,
  input  logic                           arst_n,
  // D channel
  input  logic                           d_val,
  output logic                           d_rdy,
  input  logic [lsu_pkg::data_w-1:0]     d_pc,
  input  logic [seq_num_w-1:0]           d_seq_num,
  input  logic [lsu_pkg::data_w-1:0]     d_op1,
  input  logic [lsu_pkg::data_w-1:0]     d_op2,
  input  logic [lsu_pkg::reg_addr_w-1:0] d_waddr,
  input  lsu_pkg::lsu_op_e               d_uop,
  input  logic [lsu_pkg::data_w-1:0]     d_mem_data,
  // Memory request
  output logic                           mreq_val,
  input  logic                           mreq_rdy,
  output logic                           mreq_we,
  output logic [lsu_pkg::data_w-1:0]     mreq_addr,
  output logic [lsu_pkg::data_w-1:0]     mreq_wdata,
  // In-flight queue entry
  input  logic                           q_full,
  output logic                           q_push,
  output logic [lsu_pkg::data_w-1:0]     q_pc,
  output logic [seq_num_w-1:0]           q_seq_num,
  output logic [lsu_pkg::reg_addr_w-1:0] q_waddr,
  output logic                           q_is_load
);

  import lsu_pkg::*;

  logic              rdy_en;
  logic              slot_free;
  logic [data_w-1:0] addr_sum;

  // Effective address, no alignment check
  assign addr_sum = d_op1 + d_op2;

  // Slot free when empty or handing off to memory now
  assign slot_free = !mreq_val || mreq_rdy;
  assign d_rdy     = rdy_en && slot_free && !q_full;
  assign q_push    = d_val && d_rdy;

  // Writeback fields for the queue
  assign q_pc      = d_pc;
  assign q_seq_num = d_seq_num;
  assign q_waddr   = d_waddr;
  assign q_is_load = (d_uop == op_lw);

  // Ready held off until the first edge out of reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rdy_en   <= 1'b0;
      mreq_val <= 1'b0;
    end else begin
      rdy_en <= 1'b1;
      if (q_push) begin
        mreq_val <= 1'b1;
      end else if (mreq_rdy) begin
        mreq_val <= 1'b0;
      end
    end
  end

  // Request payload
  always_ff @(posedge clk) begin
    if (q_push) begin
      mreq_we    <= (d_uop == op_sw);
      mreq_addr  <= addr_sum;
      mreq_wdata <= d_mem_data;
    end
  end

endmodule

// File: rtl/lsu_inflight_fifo.sv
//----------------------------------------------------------
// In-order queue of writeback fields
// One entry per memory request still awaiting its response
//----------------------------------------------------------

`timescale 1ns/1ns

module lsu_inflight_fifo #(
  parameter int seq_num_w      = 5,
  parameter int inflight_depth = 2
) (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic                           push,
  input  logic                           pop,
  input  logic [lsu_pkg::data_w-1:0]     in_pc,
  input  logic [seq_num_w-1:0]           in_seq_num,
  input  logic [lsu_pkg::reg_addr_w-1:0] in_waddr,
  input  logic                           in_is_load,
  output logic                           full,
  output logic [lsu_pkg::data_w-1:0]     head_pc,
  output logic [seq_num_w-1:0]           head_seq_num,
  output logic [lsu_pkg::reg_addr_w-1:0] head_waddr,
  output logic                           head_is_load
);

  import lsu_pkg::*;

  localparam int ptr_w = $clog2(inflight_depth);
  localparam int cnt_w = $clog2(inflight_depth + 1);

  // Entry storage
  logic [data_w-1:0]     pc_q    [inflight_depth];
  logic [seq_num_w-1:0]  seq_q   [inflight_depth];
  logic [reg_addr_w-1:0] waddr_q [inflight_depth];
  logic                  load_q  [inflight_depth];

  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;

  // Head slot popping now counts as free
  assign full = (count == cnt_w'(inflight_depth)) && !pop;

  assign head_pc      = pc_q[rd_ptr];
  assign head_seq_num = seq_q[rd_ptr];
  assign head_waddr   = waddr_q[rd_ptr];
  assign head_is_load = load_q[rd_ptr];

  // Pointers wrap at depth, any depth allowed
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == ptr_w'(inflight_depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_w'(inflight_depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      pc_q[wr_ptr]    <= in_pc;
      seq_q[wr_ptr]   <= in_seq_num;
      waddr_q[wr_ptr] <= in_waddr;
      load_q[wr_ptr]  <= in_is_load;
    end
  end

endmodule

// File: rtl/load_store_unit.sv
//----------------------------------------------------------
// Load-store execute unit
// Issue stage, in-flight queue and writeback formation
//----------------------------------------------------------

`timescale 1ns/1ns

module load_store_unit #(
  parameter int seq_num_w      = 5,
  parameter int inflight_depth = 2
) (
  input  logic                           clk,
  input  logic                           arst_n,
  // D channel
  input  logic                           d_val,
  output logic                           d_rdy,
  input  logic [lsu_pkg::data_w-1:0]     d_pc,
  input  logic [seq_num_w-1:0]           d_seq_num,
  input  logic [lsu_pkg::data_w-1:0]     d_op1,
  input  logic [lsu_pkg::data_w-1:0]     d_op2,
  input  logic [lsu_pkg::reg_addr_w-1:0] d_waddr,
  input  lsu_pkg::lsu_op_e               d_uop,
  input  logic [lsu_pkg::data_w-1:0]     d_mem_data,
  // W channel
  output logic                           w_val,
  input  logic                           w_rdy,
  output logic [lsu_pkg::data_w-1:0]     w_pc,
  output logic [seq_num_w-1:0]           w_seq_num,
  output logic [lsu_pkg::reg_addr_w-1:0] w_waddr,
  output logic [lsu_pkg::data_w-1:0]     w_wdata,
  output logic                           w_wen,
  // Memory request
  output logic                           mreq_val,
  input  logic                           mreq_rdy,
  output logic                           mreq_we,
  output logic [lsu_pkg::data_w-1:0]     mreq_addr,
  output logic [lsu_pkg::data_w-1:0]     mreq_wdata,
  // Memory response
  input  logic                           mresp_val,
  output logic                           mresp_rdy,
  input  logic [lsu_pkg::data_w-1:0]     mresp_rdata
);

  import lsu_pkg::*;

  logic                  q_push;
  logic                  q_pop;
  logic                  q_full;
  logic [data_w-1:0]     q_pc;
  logic [seq_num_w-1:0]  q_seq_num;
  logic [reg_addr_w-1:0] q_waddr;
  logic                  q_is_load;
  logic [data_w-1:0]     head_pc;
  logic [seq_num_w-1:0]  head_seq_num;
  logic [reg_addr_w-1:0] head_waddr;
  logic                  head_is_load;

  lsu_issue #(
    .seq_num_w (seq_num_w)
  ) u_issue (
    .clk, .arst_n,
    .d_val, .d_rdy, .d_pc, .d_seq_num, .d_op1, .d_op2,
    .d_waddr, .d_uop, .d_mem_data,
    .mreq_val, .mreq_rdy, .mreq_we, .mreq_addr, .mreq_wdata,
    .q_full, .q_push, .q_pc, .q_seq_num, .q_waddr, .q_is_load
  );

  lsu_inflight_fifo #(
    .seq_num_w      (seq_num_w),
    .inflight_depth (inflight_depth)
  ) u_inflight (
    .clk, .arst_n,
    .push         (q_push),
    .pop          (q_pop),
    .in_pc        (q_pc),
    .in_seq_num   (q_seq_num),
    .in_waddr     (q_waddr),
    .in_is_load   (q_is_load),
    .full         (q_full),
    .head_pc, .head_seq_num, .head_waddr, .head_is_load
  );

  //----------------------------------------------------------
  // Writeback, responses arrive in issue order
  //----------------------------------------------------------

  assign w_val     = mresp_val;
  assign mresp_rdy = w_rdy;
  assign q_pop     = w_val && w_rdy;

  assign w_pc      = head_pc;
  assign w_seq_num = head_seq_num;
  assign w_wen     = head_is_load;
  // Stores carry no register write
  assign w_waddr   = head_is_load ? head_waddr : '0;
  assign w_wdata   = head_is_load ? mresp_rdata : '0;

endmodule

// File: rtl/data_mem.sv
//----------------------------------------------------------
// Word-addressed data memory
// Request channel and one-entry registered response buffer
//----------------------------------------------------------

`timescale 1ns/1ns

module data_mem #(
  parameter int mem_words = 256
) (
  input  logic                       clk,
  input  logic                       arst_n,
  // Request
  input  logic                       mreq_val,
  output logic                       mreq_rdy,
  input  logic                       mreq_we,
  input  logic [lsu_pkg::data_w-1:0] mreq_addr,
  input  logic [lsu_pkg::data_w-1:0] mreq_wdata,
  // Response
  output logic                       mresp_val,
  input  logic                       mresp_rdy,
  output logic [lsu_pkg::data_w-1:0] mresp_rdata
);

  import lsu_pkg::*;

  localparam int idx_w = $clog2(mem_words);

  // Contents undefined until written
  logic [data_w-1:0] mem [mem_words];

  logic             req_fire;
  logic [idx_w-1:0] idx;

  // Word index, byte offset dropped
  assign idx = mreq_addr[idx_w+1:2];

  // Accept when buffer empty or drained this cycle
  assign mreq_rdy = !mresp_val || mresp_rdy;
  assign req_fire = mreq_val && mreq_rdy;

  //----------------------------------------------------------
  // Response buffer
  //----------------------------------------------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mresp_val <= 1'b0;
    end else if (req_fire) begin
      mresp_val <= 1'b1;
    end else if (mresp_rdy) begin
      mresp_val <= 1'b0;
    end
  end

  // Old word read out, also for stores
  always_ff @(posedge clk) begin
    if (req_fire) begin
      mresp_rdata <= mem[idx];
    end
  end

  //----------------------------------------------------------
  // Storage
  //----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (req_fire && mreq_we) begin
      mem[idx] <= mreq_wdata;
    end
  end

endmodule

// File: rtl/lsu_top.sv
//----------------------------------------------------------
// Top level, load-store unit with its data memory
//----------------------------------------------------------

`timescale 1ns/1ns

module lsu_top #(
  parameter int seq_num_w      = 5,
  parameter int inflight_depth = 2,
  parameter int mem_words      = 256
) (
  input  logic                           clk,
  input  logic                           arst_n,
  // D channel
  input  logic                           d_val,
  output logic                           d_rdy,
  input  logic [lsu_pkg::data_w-1:0]     d_pc,
  input  logic [seq_num_w-1:0]           d_seq_num,
  input  logic [lsu_pkg::data_w-1:0]     d_op1,
  input  logic [lsu_pkg::data_w-1:0]     d_op2,
  input  logic [lsu_pkg::reg_addr_w-1:0] d_waddr,
  input  lsu_pkg::lsu_op_e               d_uop,
  input  logic [lsu_pkg::data_w-1:0]     d_mem_data,
  // W channel
  output logic                           w_val,
  input  logic                           w_rdy,
  output logic [lsu_pkg::data_w-1:0]     w_pc,
  output logic [seq_num_w-1:0]           w_seq_num,
  output logic [lsu_pkg::reg_addr_w-1:0] w_waddr,
  output logic [lsu_pkg::data_w-1:0]     w_wdata,
  output logic                           w_wen
);

  import lsu_pkg::*;

  // Memory side wiring
  logic              mreq_val;
  logic              mreq_rdy;
  logic              mreq_we;
  logic [data_w-1:0] mreq_addr;
  logic [data_w-1:0] mreq_wdata;
  logic              mresp_val;
  logic              mresp_rdy;
  logic [data_w-1:0] mresp_rdata;

  load_store_unit #(
    .seq_num_w      (seq_num_w),
    .inflight_depth (inflight_depth)
  ) u_lsu (
    .clk, .arst_n,
    .d_val, .d_rdy, .d_pc, .d_seq_num, .d_op1, .d_op2,
    .d_waddr, .d_uop, .d_mem_data,
    .w_val, .w_rdy, .w_pc, .w_seq_num, .w_waddr, .w_wdata, .w_wen,
    .mreq_val, .mreq_rdy, .mreq_we, .mreq_addr, .mreq_wdata,
    .mresp_val, .mresp_rdy, .mresp_rdata
  );

  data_mem #(
    .mem_words (mem_words)
  ) u_mem (
    .clk, .arst_n,
    .mreq_val, .mreq_rdy, .mreq_we, .mreq_addr, .mreq_wdata,
    .mresp_val, .mresp_rdy, .mresp_rdata
  );

endmodule

// File: testbench/lsu_sva.sv
//----------------------------------------------------------
// Assertions bound to the load-store unit
// W and memory request stability, idle outputs in reset
//----------------------------------------------------------

`timescale 1ns/1ns

module lsu_sva #(
  parameter int seq_num_w = 5
) (
  input logic                           clk,
  input logic                           arst_n,
  input logic                           w_val,
  input logic                           w_rdy,
  input logic [lsu_pkg::data_w-1:0]     w_pc,
  input logic [seq_num_w-1:0]           w_seq_num,
  input logic [lsu_pkg::reg_addr_w-1:0] w_waddr,
  input logic [lsu_pkg::data_w-1:0]     w_wdata,
  input logic                           w_wen,
  input logic                           mreq_val,
  input logic                           mreq_rdy,
  input logic                           mreq_we,
  input logic [lsu_pkg::data_w-1:0]     mreq_addr,
  input logic [lsu_pkg::data_w-1:0]     mreq_wdata
);

  // Stalled W message held intact
  w_hold_a: assert property (@(posedge clk) disable iff (!arst_n)
    (w_val && !w_rdy) |=> (w_val && $stable(w_pc) && $stable(w_seq_num) &&
      $stable(w_waddr) && $stable(w_wdata) && $stable(w_wen)))
    else $error("W message changed while stalled");

  // Stalled memory request held intact
  mreq_hold_a: assert property (@(posedge clk) disable iff (!arst_n)
    (mreq_val && !mreq_rdy) |=> (mreq_val && $stable(mreq_we) &&
      $stable(mreq_addr) && $stable(mreq_wdata)))
    else $error("Memory request changed while stalled");

  reset_idle_a: assert property (@(posedge clk) !arst_n |-> (!w_val && !mreq_val))
    else $error("Valid raised during reset");

endmodule

bind load_store_unit lsu_sva #(
  .seq_num_w (seq_num_w)
) u_sva (
  .clk        (clk),
  .arst_n     (arst_n),
  .w_val      (w_val),
  .w_rdy      (w_rdy),
  .w_pc       (w_pc),
  .w_seq_num  (w_seq_num),
  .w_waddr    (w_waddr),
  .w_wdata    (w_wdata),
  .w_wen      (w_wen),
  .mreq_val   (mreq_val),
  .mreq_rdy   (mreq_rdy),
  .mreq_we    (mreq_we),
  .mreq_addr  (mreq_addr),
  .mreq_wdata (mreq_wdata)
);

// File: testbench/lsu_tb.sv
//----------------------------------------------------------
// Directed testbench for the load-store unit top level
// Clock, reset, send and expect tasks, memory scoreboard
//----------------------------------------------------------

`timescale 1ns/1ns

module lsu_tb;

  import lsu_pkg::*;

  localparam int seq_num_w      = 5;
  localparam int inflight_depth = 2;
  localparam int mem_words      = 256;
  localparam int idx_w          = $clog2(mem_words);
  // Budget of 300 ops at up to 13 cycles each plus reset margin
  localparam int op_budget      = 300;
  localparam int cycles_per_op  = 13;
  localparam int max_cycles     = op_budget * cycles_per_op + 100;

  logic                  clk;
  logic                  arst_n;
  logic                  d_val;
  logic                  d_rdy;
  logic [data_w-1:0]     d_pc;
  logic [seq_num_w-1:0]  d_seq_num;
  logic [data_w-1:0]     d_op1;
  logic [data_w-1:0]     d_op2;
  logic [reg_addr_w-1:0] d_waddr;
  lsu_op_e               d_uop;
  logic [data_w-1:0]     d_mem_data;
  logic                  w_val;
  logic                  w_rdy;
  logic [data_w-1:0]     w_pc;
  logic [seq_num_w-1:0]  w_seq_num;
  logic [reg_addr_w-1:0] w_waddr;
  logic [data_w-1:0]     w_wdata;
  logic                  w_wen;

  // Scoreboard memory image and expected W messages in D order
  logic [data_w-1:0]     mem_model [mem_words];
  logic [data_w-1:0]     exp_pc    [$];
  logic [seq_num_w-1:0]  exp_seq   [$];
  logic [reg_addr_w-1:0] exp_waddr [$];
  logic [data_w-1:0]     exp_wdata [$];
  logic                  exp_wen   [$];

  logic [data_w-1:0]    next_pc   = 32'h0000_1000;
  logic [seq_num_w-1:0] next_seq  = '0;
  string                test_name = "init";
  bit                   stall_mode = 1'b0;
  integer               seed      = 32'hb71;
  int                   n_sent    = 0;
  int                   n_recv    = 0;
  int                   cycle_cnt = 0;
  int                   err_data  = 0;
  int                   err_reg   = 0;
  int                   err_seq   = 0;
  int                   err_bit   = 0;
  int                   err_other = 0;

  lsu_top #(
    .seq_num_w      (seq_num_w),
    .inflight_depth (inflight_depth),
    .mem_words      (mem_words)
  ) dut (
    .clk, .arst_n,
    .d_val, .d_rdy, .d_pc, .d_seq_num, .d_op1, .d_op2,
    .d_waddr, .d_uop, .d_mem_data,
    .w_val, .w_rdy, .w_pc, .w_seq_num, .w_waddr, .w_wdata, .w_wen
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  //----------------------------------------------------------
  // Compare tasks per result type
  //----------------------------------------------------------

  task automatic check_data(input string what, input logic [data_w-1:0] exp,
                            input logic [data_w-1:0] act);
    if (act !== exp) begin
      err_data++;
      $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_reg(input string what, input logic [reg_addr_w-1:0] exp,
                           input logic [reg_addr_w-1:0] act);
    if (act !== exp) begin
      err_reg++;
      $display("ERROR %s %s: expected %0d, actual %0d", test_name, what, exp, act);
    end
  endtask

  task automatic check_seq(input string what, input logic [seq_num_w-1:0] exp,
                           input logic [seq_num_w-1:0] act);
    if (act !== exp) begin
      err_seq++;
      $display("ERROR %s %s: expected %0d, actual %0d", test_name, what, exp, act);
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      err_bit++;
      $display("ERROR %s %s: expected %b, actual %b", test_name, what, exp, act);
    end
  endtask

  // Word select drops the byte offset and the upper bits
  function automatic logic [idx_w-1:0] word_index(input logic [data_w-1:0] addr);
    return addr[idx_w+1:2];
  endfunction

  //----------------------------------------------------------
  // Channel tasks
  //----------------------------------------------------------

  // Called and returns 1 ns after a rising edge
  task automatic send_op(input lsu_op_e uop, input logic [data_w-1:0] op1,
                         input logic [data_w-1:0] op2, input logic [reg_addr_w-1:0] waddr,
                         input logic [data_w-1:0] data);
    logic [idx_w-1:0] idx;
    idx        = word_index(op1 + op2);
    d_val      = 1'b1;
    d_pc       = next_pc;
    d_seq_num  = next_seq;
    d_op1      = op1;
    d_op2      = op2;
    d_waddr    = waddr;
    d_uop      = uop;
    d_mem_data = data;
    do @(negedge clk); while (d_rdy !== 1'b1);
    // Transfer on the coming edge
    exp_pc.push_back(next_pc);
    exp_seq.push_back(next_seq);
    if (uop == op_sw) begin
      mem_model[idx] = data;
      exp_wen.push_back(1'b0);
      exp_waddr.push_back('0);
      exp_wdata.push_back('0);
    end else begin
      exp_wen.push_back(1'b1);
      exp_waddr.push_back(waddr);
      exp_wdata.push_back(mem_model[idx]);
    end
    n_sent++;
    @(posedge clk);
    #1;
    d_val    = 1'b0;
    next_pc  = next_pc + 4;
    next_seq = next_seq + 1'b1;
  endtask

  task automatic expect_wb();
    do @(negedge clk); while (!(w_val === 1'b1 && w_rdy === 1'b1));
    if (exp_pc.size() == 0) begin
      err_other++;
      $display("Writeback with pc %h arrived with no operation outstanding", w_pc);
    end else begin
      check_data("pc", exp_pc.pop_front(), w_pc);
      check_seq("seq_num", exp_seq.pop_front(), w_seq_num);
      check_reg("waddr", exp_waddr.pop_front(), w_waddr);
      check_data("wdata", exp_wdata.pop_front(), w_wdata);
      check_bit("wen", exp_wen.pop_front(), w_wen);
      n_recv++;
    end
    @(posedge clk);
  endtask

  task automatic wait_drain();
    while (exp_pc.size() != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  // Two cycles of reset and idle checks on the way out
  task automatic apply_reset();
    arst_n = 1'b0;
    repeat (2) begin
      @(posedge clk);
      #1;
      check_bit("w_val in reset", 1'b0, w_val);
      check_bit("d_rdy in reset", 1'b0, d_rdy);
    end
    arst_n = 1'b1;
    @(negedge clk);
    check_bit("w_val after reset", 1'b0, w_val);
    check_bit("d_rdy before first edge", 1'b0, d_rdy);
    @(posedge clk);
    #1;
    @(negedge clk);
    check_bit("w_val idle", 1'b0, w_val);
    check_bit("d_rdy out of reset", 1'b1, d_rdy);
    @(posedge clk);
    #1;
  endtask

  //----------------------------------------------------------
  // Tests
  //----------------------------------------------------------

  task automatic store_then_load();
    test_name = "store_load";
    for (int i = 0; i < 8; i++) begin
      send_op(op_sw, 32'h80, i * 12, 5'd31 - i, 32'hd00d_0000 + i * 32'h0001_0203);
    end
    for (int i = 0; i < 8; i++) begin
      send_op(op_lw, 32'h80 + i * 12, 32'h0, i + 1, 32'hffff_ffff);
    end
    wait_drain();
  endtask

  task automatic address_splits();
    test_name = "addr_form";
    send_op(op_lw, 32'h0000_0000, 32'h0000_0080, 5'd1, '0);
    send_op(op_lw, 32'h0000_0100, 32'hffff_ff80, 5'd2, '0);
    // Low bits set within the same word
    send_op(op_lw, 32'h0000_0081, 32'h0000_0002, 5'd3, '0);
    send_op(op_lw, 32'h0001_0000, 32'h0000_008e, 5'd4, '0);
    // Sum wraps past 2^32
    send_op(op_lw, 32'hffff_ff00, 32'h0000_0198, 5'd5, '0);
    send_op(op_lw, 32'h0000_00a8, 32'hffff_fffe, 5'd6, '0);
    // Above the memory size so aliases to 0xb0
    send_op(op_lw, 32'h0000_0400, 32'h0000_00b0, 5'd7, '0);
    wait_drain();
  endtask

  // 20 mixed ops with loads hitting words stored earlier in the stream
  task automatic run_stream(input string name, input logic [data_w-1:0] data_base);
    logic [data_w-1:0] addr;
    test_name = name;
    for (int i = 0; i < 20; i++) begin
      if (i % 2 == 0) begin
        addr = 32'h200 + i * 2;
        send_op(op_sw, addr, 32'h0, 5'(i + 1), data_base + i * 32'h0101);
      end else begin
        addr = 32'h200 + ((i - 1) & ~3) * 2;
        send_op(op_lw, addr - 8, 32'h8, 5'(i + 1), '0);
      end
    end
    wait_drain();
  endtask

  task automatic reset_and_resume();
    test_name = "reset_state";
    apply_reset();
    send_op(op_sw, 32'h300, 32'h4, 5'd9, 32'h1234_abcd);
    send_op(op_lw, 32'h304, 32'h0, 5'd9, '0);
    // Memory keeps its contents through reset
    send_op(op_lw, 32'h80, 32'hc, 5'd10, '0);
    wait_drain();
  endtask

  //----------------------------------------------------------
  // Background W receiver and its ready pattern
  //----------------------------------------------------------

  initial begin
    forever expect_wb();
  end

  initial begin
    logic [31:0] rnd;
    w_rdy = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      rnd   = $random(seed);
      w_rdy = stall_mode ? rnd[0] : 1'b1;
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= max_cycles) begin
      $display("Timeout after %0d cycles, %0d of %0d writebacks seen",
               cycle_cnt, n_recv, n_sent);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  initial begin
    d_val      = 1'b0;
    d_pc       = '0;
    d_seq_num  = '0;
    d_op1      = '0;
    d_op2      = '0;
    d_waddr    = '0;
    d_uop      = op_lw;
    d_mem_data = '0;
    test_name  = "reset";
    apply_reset();
    store_then_load();
    address_splits();
    run_stream("order_fields", 32'h600d_0000);
    stall_mode = 1'b1;
    // New store words so stalled writes must reach memory
    run_stream("back_pressure", 32'h5a11_0000);
    stall_mode = 1'b0;
    reset_and_resume();
    if (n_sent != n_recv) begin
      err_other++;
      $display("Sent %0d operations but received %0d writebacks", n_sent, n_recv);
    end
    $display("Errors: data %0d, reg %0d, seq %0d, wen %0d, other %0d",
             err_data, err_reg, err_seq, err_bit, err_other);
    if (err_data + err_reg + err_seq + err_bit + err_other == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: vlog.f
rtl/lsu_pkg.sv
rtl/lsu_issue.sv
rtl/lsu_inflight_fifo.sv
rtl/load_store_unit.sv
rtl/data_mem.sv
rtl/lsu_top.sv
testbench/lsu_sva.sv
testbench/lsu_tb.sv
